//--- verilog/vid_pkg.sv
/*
  Shared widths and payload layouts for the video subsystem.
  Counter widths must cover H_TOTAL and V_TOTAL as set at the top level.
  LINE_WORDS here is the default line length; the top level may override it.
*/
package vid_pkg;

    // ====================
    // RAM port
    // ====================
    localparam int ADDR_W = 12;                 // Word address width of the video RAM
    localparam int DATA_W = 16;                 // Data word width of the video RAM

    typedef logic [ADDR_W-1:0] vram_addr_t;
    typedef logic [DATA_W-1:0] vram_data_t;

    // ====================
    // Timing and line
    // ====================
    localparam int HCNT_W     = 6;              // Holds 0 to 63 pixels per line
    localparam int VCNT_W     = 5;              // Holds 0 to 31 lines per frame
    localparam int LINE_WORDS = 4;              // RAM words fetched per line

    // One scroll entry per RAM word
    typedef struct packed {
        logic [11:0] code;                      // Tile code
        logic [3:0]  pal;                       // Palette select
    } scr_tile_t;

    // One palette entry per RAM word
    typedef struct packed {
        logic [3:0] bright;                     // Brightness applied to all channels
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pal_color_t;

endpackage

//--- verilog/video_timing.sv
/*
  Pixel enable and raster counters.
  PXL_DIV must be 2 or more. Counters change on the cycle that pxl_cen is high,
  so pxl_cen, hcount, vcount, hb, vb and line_start always agree in one cycle.
*/
`timescale 1ns/100ps

module video_timing #(
    parameter int H_TOTAL  = 64,
    parameter int H_ACTIVE = 32,
    parameter int V_TOTAL  = 20,
    parameter int V_ACTIVE = 16,
    parameter int PXL_DIV  = 2
) (
    input  logic                      clk,
    input  logic                      arst_n,
    output logic                      pxl_cen,
    output logic                      hb,
    output logic                      vb,
    output logic                      line_start,
    output logic [vid_pkg::HCNT_W-1:0] hcount,
    output logic [vid_pkg::VCNT_W-1:0] vcount
);

    logic [$clog2(PXL_DIV)-1:0] div_cnt;           // Clock divider for the pixel enable
    logic                       cen_next;          // Pixel enable fires on the next edge
    logic                       h_wrap;
    logic                       v_wrap;
    logic [vid_pkg::HCNT_W-1:0] h_next;
    logic [vid_pkg::VCNT_W-1:0] v_next;

    assign cen_next = int'(div_cnt) == PXL_DIV - 1;
    assign h_wrap   = int'(hcount) == H_TOTAL - 1;
    assign v_wrap   = int'(vcount) == V_TOTAL - 1;
    assign h_next   = h_wrap ? '0 : hcount + 1'b1;  // Pixel after the current one
    assign v_next   = !h_wrap ? vcount : (v_wrap ? '0 : vcount + 1'b1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt    <= '0;
            pxl_cen    <= 1'b0;
            line_start <= 1'b0;
            hcount     <= '0;
            vcount     <= '0;
            hb         <= 1'b0;
            vb         <= 1'b0;
        end else begin
            div_cnt    <= cen_next ? '0 : div_cnt + 1'b1;
            pxl_cen    <= cen_next;
            line_start <= cen_next && h_wrap;      // High together with hcount 0
            if (cen_next) begin
                hcount <= h_next;
                vcount <= v_next;
                hb     <= int'(h_next) >= H_ACTIVE; // Blanking follows the new position
                vb     <= int'(v_next) >= V_ACTIVE;
            end
        end
    end

endmodule

//--- verilog/vram_arbiter.sv
/*
  Round-robin arbiter for two four-phase requesters on one RAM read port.
  One read is in flight at a time. The RAM may take any number of cycles;
  vram_ok must be a single-cycle pulse and vram_rdata valid with it.
  A requester must hold addr stable while its req is high.
*/
`timescale 1ns/100ps

module vram_arbiter (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                req_a,
    input  logic                req_b,
    input  vid_pkg::vram_addr_t addr_a,
    input  vid_pkg::vram_addr_t addr_b,
    output logic                ack_a,
    output logic                ack_b,
    output vid_pkg::vram_data_t rdata,
    output vid_pkg::vram_addr_t vram_addr,
    output logic                vram_rd,
    input  vid_pkg::vram_data_t vram_rdata,
    input  logic                vram_ok,
    output logic                contend
);

    typedef enum logic [1:0] {
        ST_IDLE,                                     // Waiting for a request
        ST_READ,                                     // RAM read in progress
        ST_ACK                                       // Ack held until req drops
    } arb_state_t;

    arb_state_t state;
    logic       last_b;                              // Current or previous grant went to b
    logic       pick_b;
    logic       owner_req;

    // b wins when alone or when a was served last
    assign pick_b    = req_b && (!req_a || !last_b);
    assign owner_req = last_b ? req_b : req_a;

    // ====================
    // Control
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            last_b  <= 1'b1;                         // First contested grant goes to a
            vram_rd <= 1'b0;
            ack_a   <= 1'b0;
            ack_b   <= 1'b0;
            contend <= 1'b0;
        end else begin
            contend <= 1'b0;
            case (state)
                ST_IDLE: if (req_a || req_b) begin
                    last_b  <= pick_b;
                    vram_rd <= 1'b1;
                    contend <= req_a && req_b;       // Other side is left waiting
                    state   <= ST_READ;
                end
                ST_READ: if (vram_ok) begin
                    vram_rd <= 1'b0;
                    ack_a   <= !last_b;
                    ack_b   <= last_b;
                    state   <= ST_ACK;
                end
                ST_ACK: if (!owner_req) begin        // Phase 4 of the handshake
                    ack_a <= 1'b0;
                    ack_b <= 1'b0;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ====================
    // Data path
    // ====================
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && (req_a || req_b)) begin
            vram_addr <= pick_b ? addr_b : addr_a;   // Held for the whole read
        end
        if (state == ST_READ && vram_ok) begin
            rdata <= vram_rdata;                     // Stays valid while ack is high
        end
    end

endmodule

//--- verilog/line_fetch.sv
/*
  Double-buffered line fetcher. On line_start the buffers swap and the words
  for the next line are read into the back buffer through a four-phase port.
  LINE_WORDS and H_ACTIVE/LINE_WORDS must be powers of two, LINE_WORDS >= 2.
  The fetch must end before the next line_start; nothing checks this here.
*/
`timescale 1ns/100ps

module line_fetch #(
    parameter type                 payload_t  = vid_pkg::vram_data_t,
    parameter vid_pkg::vram_addr_t BASE       = '0,
    parameter int                  LINE_WORDS = 4,
    parameter int                  H_ACTIVE   = 32,
    parameter int                  V_TOTAL    = 20
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       line_start,
    input  logic [vid_pkg::HCNT_W-1:0] hcount,
    input  logic [vid_pkg::VCNT_W-1:0] vcount,
    output logic                       req,
    output vid_pkg::vram_addr_t        addr,
    input  logic                       ack,
    input  vid_pkg::vram_data_t        rdata,
    output logic                       busy,
    output payload_t                   pixel_word
);

    localparam int IDX_W     = $clog2(LINE_WORDS);
    localparam int PIX_SHIFT = $clog2(H_ACTIVE / LINE_WORDS); // Pixels per word as a shift

    payload_t                   line_buf [2][LINE_WORDS];
    logic                       front;                       // Buffer on screen
    logic [IDX_W-1:0]           fetch_idx;                   // Next word to read
    vid_pkg::vram_addr_t        line_base;
    logic [vid_pkg::VCNT_W-1:0] next_line;
    logic [vid_pkg::HCNT_W-1:0] word_pos;

    assign next_line = (int'(vcount) == V_TOTAL - 1) ? '0 : vcount + 1'b1;
    assign addr      = line_base + vid_pkg::vram_addr_t'(fetch_idx);
    assign word_pos  = hcount >> PIX_SHIFT;

    // The swap lands one edge after line_start, so that cycle reads the back buffer
    assign pixel_word = line_buf[front ^ line_start][word_pos[IDX_W-1:0]];

    // ====================
    // Fetch sequence
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            front     <= 1'b0;
            busy      <= 1'b0;
            req       <= 1'b0;
            fetch_idx <= '0;
            line_base <= BASE;
        end else if (line_start) begin
            front     <= !front;
            busy      <= 1'b1;
            fetch_idx <= '0;
            line_base <= BASE + (vid_pkg::vram_addr_t'(next_line) << IDX_W);
        end else if (busy) begin
            if (!req && !ack) begin
                req <= 1'b1;                                  // Previous ack is gone
            end else if (req && ack) begin
                req <= 1'b0;                                  // Word taken this cycle
                if (&fetch_idx) begin
                    busy <= 1'b0;
                end else begin
                    fetch_idx <= fetch_idx + 1'b1;
                end
            end
        end
    end

    // Back buffer write on the acknowledged cycle
    always_ff @(posedge clk) begin
        if (busy && req && ack) begin
            line_buf[!front][fetch_idx] <= payload_t'(rdata);
        end
    end

endmodule

//--- verilog/pulse_stretch.sv
/*
  Holds a short event high for TICKS slow ticks.
  A new event reloads the count, so overlapping events merge into one pulse.
  The output lasts between TICKS-1 and TICKS tick periods plus one clock.
*/
`timescale 1ns/100ps

module pulse_stretch #(
    parameter int TICKS = 3
) (
    input  logic clk,
    input  logic arst_n,
    input  logic tick,
    input  logic pulse_in,
    output logic pulse_out
);

    logic [$clog2(TICKS+1)-1:0] remain;              // Ticks left before the output drops

    assign pulse_out = remain != '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            remain <= '0;
        end else if (pulse_in) begin
            remain <= ($clog2(TICKS+1))'(TICKS);      // Load wins over a same-cycle tick
        end else if (tick && pulse_out) begin
            remain <= remain - 1'b1;
        end
    end

endmodule

//--- verilog/activity_watch.sv
/*
  Debug activity monitor. Each event input is edge-detected, stretched over
  STRETCH_TICKS slow ticks (one per four pixels) and ORed into watch.
  Inputs may be levels or pulses; only rising edges count.
*/
`timescale 1ns/100ps

module activity_watch #(
    parameter int STRETCH_TICKS = 3
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       pxl_cen,
    input  logic [3:0] events,                       // Scroll busy, palette busy, contend, vb
    output logic       watch
);

    logic [1:0] pxl_cnt;                             // Counts pixel enables
    logic       slow_tick;                           // Every 4th pixel enable
    logic [3:0] events_q;
    logic [3:0] event_rise;
    logic [3:0] stretched;

    assign slow_tick  = pxl_cen && (&pxl_cnt);
    assign event_rise = events & ~events_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl_cnt  <= '0;
            events_q <= '0;
            watch    <= 1'b0;
        end else begin
            if (pxl_cen) begin
                pxl_cnt <= pxl_cnt + 1'b1;
            end
            events_q <= events;
            watch    <= |stretched;                  // One cycle after the OR
        end
    end

    // ====================
    // Stretchers
    // ====================
    for (genvar i = 0; i < 4; i++) begin : g_stretch
        pulse_stretch #(
            .TICKS     (STRETCH_TICKS)
        ) u_stretch (
            .clk       (clk),
            .arst_n    (arst_n),
            .tick      (slow_tick),
            .pulse_in  (event_rise[i]),
            .pulse_out (stretched[i])
        );
    end

endmodule

//--- verilog/video_subsys_top.sv
/*
  Video subsystem top. Timing, two line fetchers, RAM arbiter and watcher.
  All timing and line parameters are set here and passed down.
  The first visible line after reset shows stale buffer contents.
*/
`timescale 1ns/100ps

module video_subsys_top #(
    parameter int                  H_TOTAL       = 64,
    parameter int                  H_ACTIVE      = 32,
    parameter int                  V_TOTAL       = 20,
    parameter int                  V_ACTIVE      = 16,
    parameter int                  PXL_DIV       = 2,
    parameter int                  LINE_WORDS    = vid_pkg::LINE_WORDS,
    parameter vid_pkg::vram_addr_t SCR_BASE      = 12'h100,
    parameter vid_pkg::vram_addr_t PAL_BASE      = 12'h800,
    parameter int                  STRETCH_TICKS = 3
) (
    input  logic                       clk,
    input  logic                       arst_n,
    output vid_pkg::vram_addr_t        vram_addr,
    output logic                       vram_rd,
    input  vid_pkg::vram_data_t        vram_rdata,
    input  logic                       vram_ok,
    output logic                       pxl_cen,
    output logic                       hb,
    output logic                       vb,
    output logic [vid_pkg::HCNT_W-1:0] hcount,
    output logic [vid_pkg::VCNT_W-1:0] vcount,
    output vid_pkg::scr_tile_t         scr_word,
    output vid_pkg::pal_color_t        pal_word,
    output logic                       watch
);

    logic                line_start;
    logic                req_scr,  ack_scr,  busy_scr;
    logic                req_pal,  ack_pal,  busy_pal;
    vid_pkg::vram_addr_t addr_scr, addr_pal;
    vid_pkg::vram_data_t rdata;                      // Shared by both fetchers
    logic                contend;

    video_timing #(
        .H_TOTAL (H_TOTAL), .H_ACTIVE (H_ACTIVE),
        .V_TOTAL (V_TOTAL), .V_ACTIVE (V_ACTIVE), .PXL_DIV (PXL_DIV)
    ) u_timing (
        .clk (clk), .arst_n (arst_n), .pxl_cen (pxl_cen), .hb (hb), .vb (vb),
        .line_start (line_start), .hcount (hcount), .vcount (vcount)
    );

    // ====================
    // Line fetchers
    // ====================
    line_fetch #(
        .payload_t (vid_pkg::scr_tile_t), .BASE (SCR_BASE),
        .LINE_WORDS (LINE_WORDS), .H_ACTIVE (H_ACTIVE), .V_TOTAL (V_TOTAL)
    ) u_fetch_scr (
        .clk (clk), .arst_n (arst_n), .line_start (line_start),
        .hcount (hcount), .vcount (vcount), .req (req_scr), .addr (addr_scr),
        .ack (ack_scr), .rdata (rdata), .busy (busy_scr), .pixel_word (scr_word)
    );

    line_fetch #(
        .payload_t (vid_pkg::pal_color_t), .BASE (PAL_BASE),
        .LINE_WORDS (LINE_WORDS), .H_ACTIVE (H_ACTIVE), .V_TOTAL (V_TOTAL)
    ) u_fetch_pal (
        .clk (clk), .arst_n (arst_n), .line_start (line_start),
        .hcount (hcount), .vcount (vcount), .req (req_pal), .addr (addr_pal),
        .ack (ack_pal), .rdata (rdata), .busy (busy_pal), .pixel_word (pal_word)
    );

    vram_arbiter u_arbiter (
        .clk (clk), .arst_n (arst_n),
        .req_a (req_scr), .req_b (req_pal), .addr_a (addr_scr), .addr_b (addr_pal),
        .ack_a (ack_scr), .ack_b (ack_pal), .rdata (rdata),
        .vram_addr (vram_addr), .vram_rd (vram_rd),
        .vram_rdata (vram_rdata), .vram_ok (vram_ok), .contend (contend)
    );

    // ====================
    // Debug watch
    // ====================
    activity_watch #(
        .STRETCH_TICKS (STRETCH_TICKS)
    ) u_watch (
        .clk (clk), .arst_n (arst_n), .pxl_cen (pxl_cen),
        .events ({vb, contend, busy_pal, busy_scr}),  // Bit 0 is the scroll fetcher
        .watch (watch)
    );

endmodule

//--- tb/tb_video_subsys.sv
/*
  Testbench for the video subsystem top level.
  The RAM model answers each read 1 to 4 cycles after it sees vram_rd, with
  the address XOR 16'hA5C3 as data. Concurrent assertions do the checking,
  so the simulator must be run with assertions enabled.
  The run ends after two full frames. A watchdog stops it if frames stop coming.
*/
`timescale 1ns/100ps

module tb_video_subsys;

    // ====================
    // Parameters
    // ====================
    localparam int                  H_TOTAL       = 64;
    localparam int                  H_ACTIVE      = 32;
    localparam int                  V_TOTAL       = 20;
    localparam int                  V_ACTIVE      = 16;
    localparam int                  PXL_DIV       = 2;
    localparam int                  LINE_WORDS    = vid_pkg::LINE_WORDS;
    localparam vid_pkg::vram_addr_t SCR_BASE      = 12'h100;
    localparam vid_pkg::vram_addr_t PAL_BASE      = 12'h800;
    localparam int                  STRETCH_TICKS = 3;

    localparam int          CLK_PERIOD   = 100;                  // Clock period in ns
    localparam int          RESET_CYCLES = 16;
    localparam int          RUN_FRAMES   = 2;
    localparam int unsigned RNG_SEED     = 32'he7a51e3d;
    localparam int          WATCH_LIM    = 4 * PXL_DIV + 2;      // Line start to watch high
    localparam int          WATCH_LAG    = 2;                    // Edge detect and output flop
    localparam int          WATCH_HOLD   = (STRETCH_TICKS - 1) * 4 * PXL_DIV;
    localparam int          WATCHDOG_CYCLES = (V_TOTAL * RUN_FRAMES + 4) * H_TOTAL * PXL_DIV;

    logic                       clk;
    logic                       arst_n;
    vid_pkg::vram_addr_t        vram_addr;
    logic                       vram_rd;
    vid_pkg::vram_data_t        vram_rdata = '0;
    logic                       vram_ok    = 1'b0;
    logic                       pxl_cen, hb, vb, watch;
    logic [vid_pkg::HCNT_W-1:0] hcount, h_q;
    logic [vid_pkg::VCNT_W-1:0] vcount, v_q;
    vid_pkg::scr_tile_t         scr_word;
    vid_pkg::pal_color_t        pal_word;

    int          cycle_cnt   = 0;                                // Clock edges since time 0
    int          ram_wait    = 0;                                // Cycles left on the open read
    int          lines_seen  = 0;
    int          frames_done = 0;
    int          since_line  = 0;                                // Zero until the first line start
    int          vb_age      = 0;                                // Zero outside the window after vb rises
    int          cen_gap     = 0;
    logic        cen_seen, watch_hit, vb_q, arst_q, rd_q, ok_q, ok_qq;
    vid_pkg::vram_addr_t addr_q;
    logic        new_line, data_ok;

    int    errs  [6] = '{default: 0};
    int    hits  [6] = '{default: 0};
    string names [6] = '{"reset", "timing", "scroll data", "palette data", "ram port", "watch"};

    assign new_line = pxl_cen && hcount == '0;                   // First pixel of a line
    assign data_ok  = (lines_seen + int'(new_line)) >= 2 && pxl_cen && !hb && !vb;

    video_subsys_top #(
        .H_TOTAL (H_TOTAL), .H_ACTIVE (H_ACTIVE), .V_TOTAL (V_TOTAL),
        .V_ACTIVE (V_ACTIVE), .PXL_DIV (PXL_DIV), .LINE_WORDS (LINE_WORDS),
        .SCR_BASE (SCR_BASE), .PAL_BASE (PAL_BASE), .STRETCH_TICKS (STRETCH_TICKS)
    ) DUT (
        .clk (clk), .arst_n (arst_n), .vram_addr (vram_addr), .vram_rd (vram_rd),
        .vram_rdata (vram_rdata), .vram_ok (vram_ok), .pxl_cen (pxl_cen), .hb (hb),
        .vb (vb), .hcount (hcount), .vcount (vcount), .scr_word (scr_word),
        .pal_word (pal_word), .watch (watch)
    );

    // ====================
    // Expected values
    // ====================
    function automatic vid_pkg::vram_data_t ram_word(input vid_pkg::vram_addr_t a);
        return vid_pkg::vram_data_t'(a) ^ 16'hA5C3;              // RAM contents by address
    endfunction

    function automatic vid_pkg::vram_addr_t word_addr(input vid_pkg::vram_addr_t base,
                                                       input int h, input int v);
        return base + vid_pkg::vram_addr_t'(v * LINE_WORDS + h / (H_ACTIVE / LINE_WORDS));
    endfunction

    function automatic int h_after(input int h);
        return (h == H_TOTAL - 1) ? 0 : h + 1;
    endfunction

    function automatic int v_after(input int h, input int v);
        if (h != H_TOTAL - 1) begin
            return v;                                            // Line not finished yet
        end
        return (v == V_TOTAL - 1) ? 0 : v + 1;
    endfunction

    task automatic log_mismatch(input int idx, input string sig,
                                input logic [31:0] exp_v, input logic [31:0] got_v);
        errs[idx]++;
        $display("Mismatch at time %0t: %s expected 0x%0h, got 0x%0h", $time, sig, exp_v, got_v);
    endtask

    task automatic flag_failure(input int idx, input string what);
        errs[idx]++;
        $display("Error at time %0t: %s", $time, what);
    endtask

    // ====================
    // Clock, reset and run
    // ====================
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : main
        int total_errs;
        int total_hits;
        void'($urandom(RNG_SEED));                               // Seeds the generator once
        total_errs = 0;
        total_hits = 0;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        while (frames_done < RUN_FRAMES) @(posedge clk);         // Frame wrap seen on the outputs
        @(posedge clk);
        for (int i = 0; i < 6; i++) begin
            if (hits[i] == 0) begin
                total_errs++;                                    // A check that never ran
                $display("Test %s: never exercised", names[i]);
            end else begin
                $display("Test %s: %0d samples, %0d errors", names[i], hits[i], errs[i]);
            end
            total_errs += errs[i];
            total_hits += hits[i];
        end
        $display("Totals: %0d samples, %0d errors", total_hits, total_errs);
        if (total_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: two frames did not complete within %0d clock cycles",
                 WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    // ====================
    // RAM model
    // ====================
    always @(posedge clk) begin : ram_model
        int lat;
        if (!arst_n) begin
            vram_ok  <= 1'b0;
            ram_wait <= 0;
        end else if (vram_ok) begin
            vram_ok <= 1'b0;                                     // Answer lasts one cycle
        end else if (ram_wait != 0) begin
            ram_wait <= ram_wait - 1;
            if (ram_wait == 1) begin
                vram_ok    <= 1'b1;
                vram_rdata <= ram_word(vram_addr);
            end
        end else if (vram_rd) begin
            lat = 1 + int'($urandom % 4);                        // New read, draw its latency
            if (lat == 1) begin
                vram_ok    <= 1'b1;
                vram_rdata <= ram_word(vram_addr);
            end else begin
                ram_wait <= lat - 1;
            end
        end
    end

    // History and window counters that the assertions read
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        arst_q    <= arst_n;
        h_q       <= hcount;
        v_q       <= vcount;
        rd_q      <= vram_rd;
        addr_q    <= vram_addr;
        ok_q      <= vram_ok;
        ok_qq     <= ok_q;
        vb_q      <= vb;
        if (!arst_n) begin
            lines_seen <= 0;
            since_line <= 0;
            vb_age     <= 0;
            cen_seen   <= 1'b0;
            watch_hit  <= 1'b0;
            if (cycle_cnt > 0) begin
                hits[0] <= hits[0] + 1;
            end
        end else begin
            if (pxl_cen) begin
                cen_gap  <= 1;
                cen_seen <= 1'b1;
                hits[1]  <= hits[1] + 1;
            end else begin
                cen_gap <= cen_gap + 1;
            end
            if (new_line) begin
                lines_seen <= (lines_seen < 2) ? lines_seen + 1 : lines_seen;
                frames_done <= (vcount == '0) ? frames_done + 1 : frames_done;
                since_line <= 1;
                watch_hit  <= 1'b0;
            end else if (since_line != 0 && since_line <= WATCH_LIM) begin
                since_line <= since_line + 1;
                watch_hit  <= watch_hit || watch;
            end
            if (vb && !vb_q) begin
                vb_age <= 1;                                     // Blanking window opens
            end else if (vb_age != 0 && vb_age < WATCH_LAG + WATCH_HOLD) begin
                vb_age <= vb_age + 1;
            end else begin
                vb_age <= 0;
            end
            if (data_ok) begin
                hits[2] <= hits[2] + 1;
                hits[3] <= hits[3] + 1;
            end
            if (vram_rd || vram_ok) begin
                hits[4] <= hits[4] + 1;
            end
            if (since_line == WATCH_LIM || vb_age >= WATCH_LAG) begin
                hits[5] <= hits[5] + 1;
            end
        end
    end

    // ====================
    // Assertions
    // ====================
    reset_low_chk: assert property (@(posedge clk)
        (cycle_cnt > 0 && (!arst_n || !arst_q)) |-> !(vram_rd || watch || hb || vb))
        else log_mismatch(0, "{vram_rd,watch,hb,vb}", 32'h0,
                          32'($sampled({vram_rd, watch, hb, vb})));

    cen_period_chk: assert property (@(posedge clk) disable iff (!arst_n)
        cen_seen |-> (pxl_cen ? cen_gap == PXL_DIV : cen_gap < PXL_DIV))
        else log_mismatch(1, "pxl_cen spacing", 32'(PXL_DIV), 32'($sampled(cen_gap)));

    hcount_chk: assert property (@(posedge clk) disable iff (!arst_n)
        int'(hcount) == (pxl_cen ? h_after(int'(h_q)) : int'(h_q)))
        else log_mismatch(1, "hcount", 32'($sampled(pxl_cen) ? h_after(int'($sampled(h_q)))
                          : int'($sampled(h_q))), 32'($sampled(hcount)));

    vcount_chk: assert property (@(posedge clk) disable iff (!arst_n)
        int'(vcount) == (pxl_cen ? v_after(int'(h_q), int'(v_q)) : int'(v_q)))
        else log_mismatch(1, "vcount", 32'($sampled(pxl_cen) ? v_after(int'($sampled(h_q)),
                          int'($sampled(v_q))) : int'($sampled(v_q))), 32'($sampled(vcount)));

    blank_chk: assert property (@(posedge clk) disable iff (!arst_n)
        hb == (int'(hcount) >= H_ACTIVE) && vb == (int'(vcount) >= V_ACTIVE))
        else log_mismatch(1, "{hb,vb}", 32'({int'($sampled(hcount)) >= H_ACTIVE,
                          int'($sampled(vcount)) >= V_ACTIVE}), 32'($sampled({hb, vb})));

    scr_data_chk: assert property (@(posedge clk) disable iff (!arst_n)
        data_ok |-> vid_pkg::vram_data_t'(scr_word)
                    == ram_word(word_addr(SCR_BASE, int'(hcount), int'(vcount))))
        else log_mismatch(2, "scr_word", 32'(ram_word(word_addr(SCR_BASE,
                          int'($sampled(hcount)), int'($sampled(vcount))))),
                          32'($sampled(scr_word)));

    pal_data_chk: assert property (@(posedge clk) disable iff (!arst_n)
        data_ok |-> vid_pkg::vram_data_t'(pal_word)
                    == ram_word(word_addr(PAL_BASE, int'(hcount), int'(vcount))))
        else log_mismatch(3, "pal_word", 32'(ram_word(word_addr(PAL_BASE,
                          int'($sampled(hcount)), int'($sampled(vcount))))),
                          32'($sampled(pal_word)));

    addr_hold_chk: assert property (@(posedge clk) disable iff (!arst_n)
        (vram_rd && rd_q) |-> vram_addr == addr_q)
        else log_mismatch(4, "vram_addr", 32'($sampled(addr_q)), 32'($sampled(vram_addr)));

    rd_drop_chk: assert property (@(posedge clk) disable iff (!arst_n)
        (ok_q || ok_qq) |-> !vram_rd)
        else log_mismatch(4, "vram_rd", 32'h0, 32'($sampled(vram_rd)));

    watch_line_chk: assert property (@(posedge clk) disable iff (!arst_n)
        since_line == WATCH_LIM |-> (watch_hit || watch))
        else flag_failure(5, "watch stayed low for the whole window after a line start");

    watch_vb_chk: assert property (@(posedge clk) disable iff (!arst_n)
        (vb_age >= WATCH_LAG && vb_age < WATCH_LAG + WATCH_HOLD) |-> watch)
        else log_mismatch(5, "watch", 32'h1, 32'($sampled(watch)));

    watch_rst_chk: assert property (@(posedge clk)
        (cycle_cnt > 0 && !arst_n) |-> !watch)
        else log_mismatch(5, "watch", 32'h0, 32'($sampled(watch)));

endmodule

//--- verilog.f
verilog/vid_pkg.sv
verilog/video_timing.sv
verilog/vram_arbiter.sv
verilog/line_fetch.sv
verilog/pulse_stretch.sv
verilog/activity_watch.sv
verilog/video_subsys_top.sv
tb/tb_video_subsys.sv

//--- Makefile
# Verilator build and run of the video subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_video_subsys
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "CHECKS FAILED" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
